/* logic/mem_pkg.sv */
package mem_pkg;

    // Access size on the CPU/DMA bus
    typedef enum logic [1:0] {
        MEM_SIZE_BYTE = 2'd0,
        MEM_SIZE_HALF = 2'd1,
        MEM_SIZE_WORD = 2'd2
    } mem_size_e;

    // Memory regions, decoded from address bits 31:24
    typedef enum logic [7:0] {
        REGION_IO      = 8'h04,
        REGION_PALETTE = 8'h05,
        REGION_OAM     = 8'h07,
        REGION_NONE    = 8'hff
    } region_e;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        mem_size_e   size;
        logic        write;
    } bus_req_t;

    // Request as seen by the RAMs, address is word aligned
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  byte_we;
    } mem_port_t;

    // Graphics side byte addresses
    typedef struct packed {
        logic [31:0] oam_addr;
        logic [31:0] pal_bg_addr;
        logic [31:0] pal_obj_addr;
    } gfx_rd_t;

    typedef struct packed {
        logic [31:0] oam_data;
        logic [31:0] pal_bg_data;
        logic [31:0] pal_obj_data;
    } gfx_data_t;

    localparam logic [31:0] IO_BASE = 32'h0400_0000;
    localparam int NUM_IO_REGS  = 8;

    // Word indices of the registers with special fields
    localparam int KEYINPUT_IDX = 0;
    localparam int VCOUNT_IDX   = 1;
    localparam int IF_IDX       = 2;
    localparam int TM0_IDX      = 3;
    localparam int TM1_IDX      = 4;

    localparam int PAL_DEPTH = 128;
    localparam int OAM_DEPTH = 256;

endpackage : mem_pkg

/* logic/byte_lane_decoder.sv */
`timescale 1ns/1ps

module byte_lane_decoder import mem_pkg::*; (
    input  logic [1:0] addr_low,
    input  mem_size_e  size,
    input  logic       write,
    output logic [3:0] byte_we
);

    // Data arrives little endian, so lanes follow the low address bits
    always_comb begin
        byte_we = 4'b0000;
        if (write) begin
            case (size)
                MEM_SIZE_WORD: begin
                    byte_we = 4'b1111;
                end
                MEM_SIZE_HALF: begin
                    byte_we = addr_low[1] ? 4'b1100 : 4'b0011;
                end
                MEM_SIZE_BYTE: begin
                    byte_we = 4'b0001 << addr_low;
                end
                default: begin
                    byte_we = 4'b0000;
                end
            endcase
        end
    end

endmodule : byte_lane_decoder

/* logic/bus_write_stage.sv */
`timescale 1ns/1ps

module bus_write_stage import mem_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  bus_req_t  bus_req,
    output logic      pause,
    output bus_req_t  req_lat,
    output mem_port_t mem_port
);

    logic        commit;
    logic [31:0] mem_addr;

    // Bus request delayed by one cycle
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            req_lat <= '0;
        end else begin
            req_lat <= bus_req;
        end
    end

    // One pause cycle per write, the master holds its request meanwhile
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pause <= 1'b0;
        end else begin
            pause <= bus_req.write & ~pause;
        end
    end

    // Only the paused cycle commits, so the held copy is not written twice
    assign commit   = req_lat.write & pause;
    assign mem_addr = commit ? req_lat.addr : bus_req.addr;

    assign mem_port.addr  = {mem_addr[31:2], 2'b00};
    assign mem_port.wdata = req_lat.wdata;

    byte_lane_decoder i_lanes (
        .addr_low (req_lat.addr[1:0]),
        .size     (req_lat.size),
        .write    (commit),
        .byte_we  (mem_port.byte_we)
    );

endmodule : bus_write_stage

/* logic/dual_port_ram.sv */
`timescale 1ns/1ps

module dual_port_ram #(
    parameter int DEPTH = 128
) (
    input  logic                     clock,
    input  logic [$clog2(DEPTH)-1:0] a_addr,
    input  logic [31:0]              a_wdata,
    input  logic [3:0]               a_we,
    output logic [31:0]              a_rdata,
    input  logic [$clog2(DEPTH)-1:0] b_addr,
    output logic [31:0]              b_rdata
);

    logic [31:0] mem [DEPTH];
    logic [31:0] a_next;

    // Merge the enabled byte lanes into the stored word
    always_comb begin
        a_next = mem[a_addr];
        for (int i = 0; i < 4; i++) begin
            if (a_we[i]) begin
                a_next[8*i +: 8] = a_wdata[8*i +: 8];
            end
        end
    end

    // Port A is write first
    always_ff @(posedge clock) begin
        if (|a_we) begin
            mem[a_addr] <= a_next;
        end
        a_rdata <= a_next;
    end

    // Graphics read port
    always_ff @(posedge clock) begin
        b_rdata <= mem[b_addr];
    end

endmodule : dual_port_ram

/* logic/palette_mem.sv */
`timescale 1ns/1ps

module palette_mem import mem_pkg::*; #(
    parameter int DEPTH = 128
) (
    input  logic        clock,
    input  mem_port_t   mem_port,
    input  logic [3:0]  we,
    input  logic [31:0] bg_addr,
    input  logic [31:0] obj_addr,
    output logic [31:0] bg_data,
    output logic [31:0] obj_data,
    output logic [31:0] bus_rdata
);

    localparam int AW = $clog2(DEPTH);

    logic [3:0]  bg_we;
    logic [3:0]  obj_we;
    logic [31:0] bg_rdata;
    logic [31:0] obj_rdata;
    logic        obj_sel_lat;

    // Object palette sits in the upper half of the region
    assign bg_we  = mem_port.addr[9] ? 4'b0000 : we;
    assign obj_we = mem_port.addr[9] ? we : 4'b0000;

    always_ff @(posedge clock) begin
        obj_sel_lat <= mem_port.addr[9];
    end

    assign bus_rdata = obj_sel_lat ? obj_rdata : bg_rdata;

    dual_port_ram #(.DEPTH(DEPTH)) i_bg_ram (
        .clock   (clock),
        .a_addr  (mem_port.addr[AW+1:2]),
        .a_wdata (mem_port.wdata),
        .a_we    (bg_we),
        .a_rdata (bg_rdata),
        .b_addr  (bg_addr[AW+1:2]),
        .b_rdata (bg_data)
    );

    dual_port_ram #(.DEPTH(DEPTH)) i_obj_ram (
        .clock   (clock),
        .a_addr  (mem_port.addr[AW+1:2]),
        .a_wdata (mem_port.wdata),
        .a_we    (obj_we),
        .a_rdata (obj_rdata),
        .b_addr  (obj_addr[AW+1:2]),
        .b_rdata (obj_data)
    );

endmodule : palette_mem

/* logic/io_reg_file.sv */
`timescale 1ns/1ps

module io_reg_file import mem_pkg::*; (
    input  logic                           clock,
    input  logic                           reset,
    input  logic [$clog2(NUM_IO_REGS)-1:0] word_index,
    input  logic [31:0]                    wdata,
    input  logic [3:0]                     we,
    input  logic [15:0]                    buttons,
    input  logic [15:0]                    vcount,
    input  logic [15:0]                    reg_if,
    input  logic [15:0]                    tm0_count,
    input  logic [15:0]                    tm1_count,
    output logic [31:0]                    rdata,
    output logic [15:0]                    int_acks,
    output logic [15:0]                    tm0_reload,
    output logic [15:0]                    tm1_reload
);

    logic [31:0] regs [NUM_IO_REGS];

    // Lanes backed by external inputs are never stored
    function automatic logic lane_writable(input int idx, input int lane);
        logic read_only;
        read_only = (idx == KEYINPUT_IDX && lane < 2) ||
                    (idx == VCOUNT_IDX && lane >= 2);
        return !read_only;
    endfunction

    // IACK and the timer control halves are one-cycle pulses
    function automatic logic lane_pulse(input int idx, input int lane);
        logic pulse_reg;
        pulse_reg = (idx == IF_IDX) || (idx == TM0_IDX) || (idx == TM1_IDX);
        return pulse_reg && lane >= 2;
    endfunction

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_IO_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_IO_REGS; i++) begin
                for (int b = 0; b < 4; b++) begin
                    if (word_index == i && we[b] && lane_writable(i, b)) begin
                        regs[i][8*b +: 8] <= wdata[8*b +: 8];
                    end else if (lane_pulse(i, b)) begin
                        regs[i][8*b +: 8] <= 8'h00;
                    end
                end
            end
        end
    end

    // Read data, with live values replacing the read-only halves
    always_comb begin
        rdata = regs[word_index];
        case (word_index)
            KEYINPUT_IDX: rdata[15:0]  = buttons;
            VCOUNT_IDX:   rdata[31:16] = vcount;
            IF_IDX:       rdata[31:16] = reg_if;
            TM0_IDX:      rdata[15:0]  = tm0_count;
            TM1_IDX:      rdata[15:0]  = tm1_count;
            default:      rdata        = regs[word_index];
        endcase
    end

    assign int_acks   = regs[IF_IDX][31:16];
    assign tm0_reload = regs[TM0_IDX][15:0];
    assign tm1_reload = regs[TM1_IDX][15:0];

endmodule : io_reg_file

/* logic/mem_top.sv */
`timescale 1ns/1ps

module mem_top import mem_pkg::*; #(
    parameter int PAL_DEPTH = mem_pkg::PAL_DEPTH,
    parameter int OAM_DEPTH = mem_pkg::OAM_DEPTH
) (
    input  logic        clock,
    input  logic        reset,
    input  bus_req_t    bus_req,
    output logic        pause,
    output logic [31:0] bus_rdata,
    input  gfx_rd_t     gfx_rd,
    output gfx_data_t   gfx_data,
    input  logic [15:0] buttons,
    input  logic [15:0] vcount,
    input  logic [15:0] reg_if,
    input  logic [15:0] tm0_count,
    input  logic [15:0] tm1_count,
    output logic [15:0] int_acks,
    output logic [15:0] tm0_reload,
    output logic [15:0] tm1_reload
);

    localparam int OAM_AW = $clog2(OAM_DEPTH);

    bus_req_t    req_lat;
    mem_port_t   mem_port;
    region_e     region;
    logic [31:0] io_offset;
    logic        io_hit;
    logic [3:0]  pal_we;
    logic [3:0]  oam_we;
    logic [3:0]  io_we;
    logic [31:0] pal_rdata;
    logic [31:0] oam_rdata;
    logic [31:0] io_rdata;

    bus_write_stage i_write_stage (
        .clock    (clock),
        .reset    (reset),
        .bus_req  (bus_req),
        .pause    (pause),
        .req_lat  (req_lat),
        .mem_port (mem_port)
    );

    // Region of the delayed access, used for write gating and read select
    always_comb begin
        case (req_lat.addr[31:24])
            REGION_IO:      region = REGION_IO;
            REGION_PALETTE: region = REGION_PALETTE;
            REGION_OAM:     region = REGION_OAM;
            default:        region = REGION_NONE;
        endcase
    end

    assign io_offset = req_lat.addr - IO_BASE;
    assign io_hit    = (region == REGION_IO) && (io_offset[31:2] < NUM_IO_REGS);

    assign pal_we = (region == REGION_PALETTE) ? mem_port.byte_we : 4'b0000;
    assign oam_we = (region == REGION_OAM) ? mem_port.byte_we : 4'b0000;
    assign io_we  = io_hit ? mem_port.byte_we : 4'b0000;

    palette_mem #(.DEPTH(PAL_DEPTH)) i_palette (
        .clock     (clock),
        .mem_port  (mem_port),
        .we        (pal_we),
        .bg_addr   (gfx_rd.pal_bg_addr),
        .obj_addr  (gfx_rd.pal_obj_addr),
        .bg_data   (gfx_data.pal_bg_data),
        .obj_data  (gfx_data.pal_obj_data),
        .bus_rdata (pal_rdata)
    );

    dual_port_ram #(.DEPTH(OAM_DEPTH)) i_oam (
        .clock   (clock),
        .a_addr  (mem_port.addr[OAM_AW+1:2]),
        .a_wdata (mem_port.wdata),
        .a_we    (oam_we),
        .a_rdata (oam_rdata),
        .b_addr  (gfx_rd.oam_addr[OAM_AW+1:2]),
        .b_rdata (gfx_data.oam_data)
    );

    io_reg_file i_io_regs (
        .clock      (clock),
        .reset      (reset),
        .word_index (io_offset[$clog2(NUM_IO_REGS)+1:2]),
        .wdata      (mem_port.wdata),
        .we         (io_we),
        .buttons    (buttons),
        .vcount     (vcount),
        .reg_if     (reg_if),
        .tm0_count  (tm0_count),
        .tm1_count  (tm1_count),
        .rdata      (io_rdata),
        .int_acks   (int_acks),
        .tm0_reload (tm0_reload),
        .tm1_reload (tm1_reload)
    );

    // Unmapped addresses read as zero
    always_comb begin
        if (region == REGION_PALETTE) begin
            bus_rdata = pal_rdata;
        end else if (region == REGION_OAM) begin
            bus_rdata = oam_rdata;
        end else if (io_hit) begin
            bus_rdata = io_rdata;
        end else begin
            bus_rdata = 32'h0000_0000;
        end
    end

endmodule : mem_top

/* tests/tb_mem_top.sv */
`timescale 1ns/1ps

module tb_mem_top import mem_pkg::*; ();

    localparam int CLK_PERIOD = 4;
    localparam logic [31:0] SEED = 32'h2e93fe3a;

    typedef enum logic [1:0] {
        OP_WRITE = 2'd0,
        OP_READ  = 2'd1,
        OP_GFX   = 2'd2
    } op_kind_e;

    // Expected value holds read data or the IACK pulse that a write raises
    typedef struct packed {
        op_kind_e    op;
        logic [31:0] addr;
        logic [31:0] data;
        mem_size_e   size;
        logic [31:0] exp;
    } op_t;

    logic        clock;
    logic        reset;
    bus_req_t    bus_req;
    logic        pause;
    logic [31:0] bus_rdata;
    gfx_rd_t     gfx_rd;
    gfx_data_t   gfx_data;
    logic [15:0] buttons;
    logic [15:0] vcount;
    logic [15:0] reg_if;
    logic [15:0] tm0_count;
    logic [15:0] tm1_count;
    logic [15:0] int_acks;
    logic [15:0] tm0_reload;
    logic [15:0] tm1_reload;

    op_t         ops[$];
    logic [31:0] model [logic [31:0]];
    logic [31:0] lcg_state;
    logic        table_ready;
    int          errors;
    int          checks;

    mem_top #(.PAL_DEPTH(PAL_DEPTH), .OAM_DEPTH(OAM_DEPTH)) i_dut (
        .clock      (clock),
        .reset      (reset),
        .bus_req    (bus_req),
        .pause      (pause),
        .bus_rdata  (bus_rdata),
        .gfx_rd     (gfx_rd),
        .gfx_data   (gfx_data),
        .buttons    (buttons),
        .vcount     (vcount),
        .reg_if     (reg_if),
        .tm0_count  (tm0_count),
        .tm1_count  (tm1_count),
        .int_acks   (int_acks),
        .tm0_reload (tm0_reload),
        .tm1_reload (tm1_reload)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch %s expected %h actual %h", name, exp, act);
        end
    endtask

    // Words hit every lane, halfwords the pair picked by bit 1 and bytes one lane
    function automatic logic lane_hit(input logic [1:0] low, input mem_size_e size,
                                      input int lane);
        case (size)
            MEM_SIZE_WORD: return 1'b1;
            MEM_SIZE_HALF: return (lane / 2) == low[1];
            default:       return lane == low;
        endcase
    endfunction

    function automatic logic is_ram(input logic [31:0] addr);
        return addr[31:24] == REGION_PALETTE || addr[31:24] == REGION_OAM;
    endfunction

    function automatic logic io_mapped(input logic [31:0] addr);
        return addr[31:24] == REGION_IO && (addr - IO_BASE) < 32'(4 * NUM_IO_REGS);
    endfunction

    // Updates the model and returns the IACK value the write should pulse
    function automatic logic [31:0] model_write(input logic [31:0] addr,
                                                input logic [31:0] data,
                                                input mem_size_e size);
        logic [31:0] word;
        logic [31:0] v;
        logic [31:0] ack;
        int          idx;
        logic        read_only;
        logic        pulse;
        word = {addr[31:2], 2'b00};
        ack  = '0;
        idx  = int'((word - IO_BASE) >> 2);
        v    = model.exists(word) ? model[word] : 'x;
        for (int b = 0; b < 4; b++) begin
            read_only = (idx == KEYINPUT_IDX && b < 2) || (idx == VCOUNT_IDX && b >= 2);
            pulse = (idx == IF_IDX || idx == TM0_IDX || idx == TM1_IDX) && b >= 2;
            if (!lane_hit(addr[1:0], size, b)) begin
                continue;
            end
            if (is_ram(addr)) begin
                v[8*b +: 8] = data[8*b +: 8];
            end else if (io_mapped(word) && pulse) begin
                // Pulse halves are not stored and read back as zero
                if (idx == IF_IDX) begin
                    ack[8*(b-2) +: 8] = data[8*b +: 8];
                end
            end else if (io_mapped(word) && !read_only) begin
                v[8*b +: 8] = data[8*b +: 8];
            end
        end
        if (is_ram(addr) || io_mapped(word)) begin
            model[word] = v;
        end
        return ack;
    endfunction

    function automatic logic [31:0] expected_read(input logic [31:0] addr);
        logic [31:0] word;
        logic [31:0] v;
        int          idx;
        word = {addr[31:2], 2'b00};
        v    = '0;
        idx  = int'((word - IO_BASE) >> 2);
        if (is_ram(addr)) begin
            v = model[word];
        end else if (io_mapped(word)) begin
            v = model[word];
            case (idx)
                KEYINPUT_IDX: v[15:0]  = buttons;
                VCOUNT_IDX:   v[31:16] = vcount;
                IF_IDX:       v[31:16] = reg_if;
                TM0_IDX:      v[15:0]  = tm0_count;
                TM1_IDX:      v[15:0]  = tm1_count;
                default:      v        = model[word];
            endcase
        end
        return v;
    endfunction

    task automatic add_op(input op_kind_e op, input logic [31:0] addr,
                          input logic [31:0] data, input mem_size_e size);
        op_t o;
        o.op   = op;
        o.addr = addr;
        o.data = data;
        o.size = size;
        o.exp  = (op == OP_WRITE) ? model_write(addr, data, size) : expected_read(addr);
        ops.push_back(o);
    endtask

    task automatic build_table();
        logic [31:0] bases [3];
        logic [31:0] a;
        bases[0] = 32'h0500_0000;
        bases[1] = 32'h0500_0200;
        bases[2] = 32'h0700_0000;
        for (int r = 0; r < 3; r++) begin
            for (int k = 0; k < 4; k++) begin
                a = bases[r] + 32'(4 * k);
                add_op(OP_WRITE, a, lcg_next(), MEM_SIZE_WORD);
                add_op(OP_READ, a, 32'h0, MEM_SIZE_WORD);
                add_op(OP_WRITE, a + 32'(k), lcg_next(), MEM_SIZE_BYTE);
                add_op(OP_WRITE, a + 32'(2 * (k % 2)), lcg_next(), MEM_SIZE_HALF);
                add_op(OP_READ, a, 32'h0, MEM_SIZE_WORD);
            end
            for (int k = 0; k < 4; k++) begin
                add_op(OP_GFX, bases[r] + 32'(4 * k), 32'h0, MEM_SIZE_WORD);
            end
        end
        add_op(OP_WRITE, 32'h0700_03fc, lcg_next(), MEM_SIZE_WORD);
        add_op(OP_READ, 32'h0700_03fc, 32'h0, MEM_SIZE_WORD);
        add_op(OP_GFX, 32'h0700_03fc, 32'h0, MEM_SIZE_WORD);
        // Back to back reads across both banks and OAM
        for (int k = 0; k < 12; k++) begin
            add_op(OP_READ, bases[k % 3] + 32'(4 * (k / 3)), 32'h0, MEM_SIZE_WORD);
        end
        // Full words also land on the read-only and pulse halves
        for (int i = 0; i < NUM_IO_REGS; i++) begin
            add_op(OP_WRITE, IO_BASE + 32'(4 * i), lcg_next(), MEM_SIZE_WORD);
            add_op(OP_READ, IO_BASE + 32'(4 * i), 32'h0, MEM_SIZE_WORD);
        end
        add_op(OP_WRITE, IO_BASE + 32'h0a, lcg_next(), MEM_SIZE_HALF);
        add_op(OP_WRITE, IO_BASE + 32'h0b, lcg_next(), MEM_SIZE_BYTE);
        add_op(OP_WRITE, IO_BASE + 32'h0c, lcg_next(), MEM_SIZE_HALF);
        add_op(OP_WRITE, IO_BASE + 32'h12, lcg_next(), MEM_SIZE_HALF);
        for (int i = 0; i < NUM_IO_REGS; i++) begin
            add_op(OP_READ, IO_BASE + 32'(4 * i), 32'h0, MEM_SIZE_WORD);
        end
        // Past the last register and outside every region
        add_op(OP_WRITE, IO_BASE + 32'h20, lcg_next(), MEM_SIZE_WORD);
        add_op(OP_READ, IO_BASE + 32'h20, 32'h0, MEM_SIZE_WORD);
        add_op(OP_READ, IO_BASE + 32'h3c, 32'h0, MEM_SIZE_WORD);
        add_op(OP_WRITE, 32'h0600_0000, lcg_next(), MEM_SIZE_WORD);
        add_op(OP_READ, 32'h0600_0000, 32'h0, MEM_SIZE_WORD);
        add_op(OP_READ, 32'h0000_0010, 32'h0, MEM_SIZE_WORD);
        // Mapped words that an unmapped write could alias onto
        add_op(OP_READ, IO_BASE, 32'h0, MEM_SIZE_WORD);
        add_op(OP_READ, 32'h0500_0000, 32'h0, MEM_SIZE_WORD);
        add_op(OP_READ, 32'h0700_0000, 32'h0, MEM_SIZE_WORD);
    endtask

    task automatic apply_op(input op_t o, input int n);
        string       name;
        logic [31:0] got;
        name = $sformatf("op%0d %s %h", n, o.op.name(), o.addr);
        case (o.op)
            OP_WRITE: begin
                bus_req = '{o.addr, o.data, o.size, 1'b1};
                @(negedge clock);
                check_value({name, " pause"}, 32'h1, pause);
                check_value({name, " int_acks idle"}, 32'h0, int_acks);
                // Request stays held while paused
                @(negedge clock);
                check_value({name, " pause end"}, 32'h0, pause);
                check_value({name, " int_acks"}, o.exp, int_acks);
            end
            OP_READ: begin
                bus_req = '{o.addr, 32'h0, o.size, 1'b0};
                @(negedge clock);
                check_value({name, " pause"}, 32'h0, pause);
                check_value({name, " int_acks idle"}, 32'h0, int_acks);
                check_value({name, " rdata"}, o.exp, bus_rdata);
            end
            default: begin
                bus_req.write = 1'b0;
                if (o.addr[31:24] == REGION_OAM) begin
                    gfx_rd.oam_addr = o.addr;
                end else if (o.addr[9]) begin
                    gfx_rd.pal_obj_addr = o.addr;
                end else begin
                    gfx_rd.pal_bg_addr = o.addr;
                end
                @(negedge clock);
                if (o.addr[31:24] == REGION_OAM) begin
                    got = gfx_data.oam_data;
                end else if (o.addr[9]) begin
                    got = gfx_data.pal_obj_data;
                end else begin
                    got = gfx_data.pal_bg_data;
                end
                check_value({name, " gfx"}, o.exp, got);
            end
        endcase
    endtask

    initial begin
        wait (table_ready);
        #((ops.size() * 10 + 10) * CLK_PERIOD);
        $display("Timeout: the stimulus table did not finish in time");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        errors      = 0;
        checks      = 0;
        table_ready = 1'b0;
        lcg_state   = SEED;
        reset       = 1'b1;
        bus_req     = '0;
        gfx_rd      = '0;
        buttons     = 16'(lcg_next());
        vcount      = 16'(lcg_next());
        reg_if      = 16'(lcg_next());
        tm0_count   = 16'(lcg_next());
        tm1_count   = 16'(lcg_next());
        // I/O registers come out of reset as zero
        for (int i = 0; i < NUM_IO_REGS; i++) begin
            model[IO_BASE + 32'(4 * i)] = 32'h0;
        end
        build_table();
        table_ready = 1'b1;
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        check_value("pause after reset", 32'h0, pause);
        foreach (ops[n]) begin
            apply_op(ops[n], n);
        end
        check_value("tm0_reload", {16'h0, model[IO_BASE + 32'h0c][15:0]}, tm0_reload);
        check_value("tm1_reload", {16'h0, model[IO_BASE + 32'h10][15:0]}, tm1_reload);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule : tb_mem_top

/* sim.f */
logic/mem_pkg.sv
logic/byte_lane_decoder.sv
logic/bus_write_stage.sv
logic/dual_port_ram.sv
logic/palette_mem.sv
logic/io_reg_file.sv
logic/mem_top.sv
tests/tb_mem_top.sv
